// File: Bender.yml
package:
  name: core_slice

sources:
  - files:
      - logic/cpu_pkg.sv
      - logic/gpr_file.sv
      - logic/id_decoder.sv
      - logic/id_reg.sv
      - logic/ex_stage.sv
      - logic/core_top.sv
  - target: test
    files:
      - test/core_tb.sv

// File: build.f
logic/cpu_pkg.sv
logic/gpr_file.sv
logic/id_decoder.sv
logic/id_reg.sv
logic/ex_stage.sv
logic/core_top.sv
test/core_tb.sv

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      hold,     // freezes decode and ID/EX
	input  fetch_t    fetch,
	output redirect_t redirect, // also the ID/EX flush
	output commit_t   commit
);

	logic [REG_ADDR_W-1:0] ra_addr;
	logic [REG_ADDR_W-1:0] rb_addr;
	logic [WORD_W-1:0]     ra_data;
	logic [WORD_W-1:0]     rb_data;
	id_ex_t                dec;    // decoder out
	id_ex_t                id;     // ID/EX out
	fwd_t                  ex_fwd;
	fwd_t                  wb_fwd; // forwarding and file write

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	gpr_file u_gpr_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.wr      (wb_fwd),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	id_decoder u_id_decoder (
		.fetch   (fetch),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.ex_fwd  (ex_fwd),
		.wb_fwd  (wb_fwd),
		.dec     (dec)
	);

	id_reg u_id_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.hold  (hold),
		.flush (redirect.valid),
		.dec   (dec),
		.id    (id)
	);

	// ------------------------------------------------------------------------
	// execute and writeback
	// ------------------------------------------------------------------------
	ex_stage u_ex_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.id       (id),
		.ex_fwd   (ex_fwd),
		.wb_fwd   (wb_fwd),
		.redirect (redirect),
		.commit   (commit)
	);

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------
	localparam int WORD_W     = 32; // data word and instruction
	localparam int REG_ADDR_W = 5;
	localparam int NUM_GPR    = 32;
	localparam int OPC_W      = 6;  // instr[31:26]
	localparam int IMM_W      = 16; // instr[15:0], overlaps rb

	// ------------------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------------------
	typedef enum logic [OPC_W-1:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_SLT  = 6'h06,
		OP_ADDI = 6'h07, // ra + sext(imm)
		OP_LUI  = 6'h08, // imm << 16
		OP_BEQ  = 6'h09, // no register write
		OP_JAL  = 6'h0a  // dst <= pc+1
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_NOP    = 4'h0,
		ALU_ADD    = 4'h1,
		ALU_SUB    = 4'h2,
		ALU_AND    = 4'h3,
		ALU_OR     = 4'h4,
		ALU_XOR    = 4'h5,
		ALU_SLT    = 4'h6, // signed compare
		ALU_PASS_B = 4'h7
	} alu_op_e;

	typedef enum logic {
		EX_SEL_ALU  = 1'b0,
		EX_SEL_LINK = 1'b1
	} ex_sel_e;

	// ------------------------------------------------------------------------
	// pipeline structs
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic              valid;
		logic [WORD_W-1:0] pc;
		logic [WORD_W-1:0] instr;
	} fetch_t;

	typedef struct packed {
		logic                  en;        // slot holds a real instruction
		alu_op_e               alu_op;
		logic [WORD_W-1:0]     alu_in_0;
		logic [WORD_W-1:0]     alu_in_1;
		logic [WORD_W-1:0]     ra_val;    // compare operands for beq
		logic [WORD_W-1:0]     rb_val;
		logic                  is_branch;
		logic                  is_jump;
		logic [WORD_W-1:0]     target;    // pc + sext(imm)
		logic [REG_ADDR_W-1:0] dst_addr;
		logic                  gpr_we;
		ex_sel_e               ex_sel;
		logic [WORD_W-1:0]     link_val;  // pc+1
	} id_ex_t;

	typedef struct packed {
		logic                  we;
		logic [REG_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     data;
	} fwd_t;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] dst;
		logic [WORD_W-1:0]     data;
	} commit_t;

	typedef struct packed {
		logic              valid;
		logic [WORD_W-1:0] target;
	} redirect_t;

	// empty ID/EX slot, also the reset value
	localparam id_ex_t ID_EX_BUBBLE = '{
		en:        1'b0,
		alu_op:    ALU_NOP,
		alu_in_0:  '0,
		alu_in_1:  '0,
		ra_val:    '0,
		rb_val:    '0,
		is_branch: 1'b0,
		is_jump:   1'b0,
		target:    '0,
		dst_addr:  '0,
		gpr_we:    1'b0,
		ex_sel:    EX_SEL_ALU,
		link_val:  '0
	};

endpackage

// File: logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      hold,
	input  id_ex_t    id,
	output fwd_t      ex_fwd,   // combinational result
	output fwd_t      wb_fwd,   // writeback register, also the file write
	output redirect_t redirect,
	output commit_t   commit
);

	logic [WORD_W-1:0]     alu_res;
	logic [WORD_W-1:0]     result;
	logic                  taken;
	logic                  ex_we;
	logic                  wb_valid; // control, reset
	logic [REG_ADDR_W-1:0] wb_dst;   // payload, no reset
	logic [WORD_W-1:0]     wb_data;

	// ------------------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------------------
	always_comb begin
		case (id.alu_op)
			ALU_ADD:    alu_res = id.alu_in_0 + id.alu_in_1;
			ALU_SUB:    alu_res = id.alu_in_0 - id.alu_in_1;
			ALU_AND:    alu_res = id.alu_in_0 & id.alu_in_1;
			ALU_OR:     alu_res = id.alu_in_0 | id.alu_in_1;
			ALU_XOR:    alu_res = id.alu_in_0 ^ id.alu_in_1;
			ALU_SLT: begin
				alu_res = {{(WORD_W-1){1'b0}},
					$signed(id.alu_in_0) < $signed(id.alu_in_1)};
			end
			ALU_PASS_B: alu_res = id.alu_in_1; // lui
			default:    alu_res = '0;          // nop, beq
		endcase
	end

	assign result = (id.ex_sel == EX_SEL_LINK) ? id.link_val : alu_res;
	assign ex_we  = id.en & id.gpr_we;

	assign ex_fwd = '{we: ex_we, addr: id.dst_addr, data: result};

	// ------------------------------------------------------------------------
	// branch / jump
	// ------------------------------------------------------------------------
	assign taken = id.is_jump | (id.is_branch & (id.ra_val == id.rb_val));

	// no redirect while held, the instr is still waiting
	assign redirect = '{valid: id.en & taken & ~hold, target: id.target};

	// ------------------------------------------------------------------------
	// writeback register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_we & ~hold; // held instr retires later, once
		end
	end

	always_ff @(posedge clk) begin
		wb_dst  <= id.dst_addr;
		wb_data <= result;
	end

	assign wb_fwd = '{we: wb_valid, addr: wb_dst, data: wb_data};

	// dst 0 still reported, data as computed
	assign commit = '{valid: wb_valid, dst: wb_dst, data: wb_data};

endmodule

// File: logic/gpr_file.sv
`timescale 1ns/1ps

module gpr_file
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] ra_addr,
	input  logic [REG_ADDR_W-1:0] rb_addr,
	input  fwd_t                  wr,      // from the writeback register
	output logic [WORD_W-1:0]     ra_data,
	output logic [WORD_W-1:0]     rb_data
);

	logic [WORD_W-1:0] regs [NUM_GPR];

	// ------------------------------------------------------------------------
	// write port
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_GPR; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.we && wr.addr != '0) begin // r0 stays zero
			regs[wr.addr] <= wr.data;
		end
	end

	// ------------------------------------------------------------------------
	// read ports, combinational
	// ------------------------------------------------------------------------
	always_comb begin
		ra_data = regs[ra_addr];
		rb_data = regs[rb_addr];
		// r0 forced, even if something slipped in
		if (ra_addr == '0) begin
			ra_data = '0;
		end
		if (rb_addr == '0) begin
			rb_data = '0;
		end
	end

endmodule

// File: logic/id_decoder.sv
`timescale 1ns/1ps

module id_decoder
	import cpu_pkg::*;
(
	input  fetch_t                fetch,
	output logic [REG_ADDR_W-1:0] ra_addr,
	output logic [REG_ADDR_W-1:0] rb_addr,
	input  logic [WORD_W-1:0]     ra_data,
	input  logic [WORD_W-1:0]     rb_data,
	input  fwd_t                  ex_fwd,  // instr now in ID/EX
	input  fwd_t                  wb_fwd,  // writeback register
	output id_ex_t                dec
);

	opcode_e               op;
	logic [REG_ADDR_W-1:0] dst;
	logic [IMM_W-1:0]      imm;
	logic [WORD_W-1:0]     imm_sext;
	logic [WORD_W-1:0]     imm_hi;
	logic [WORD_W-1:0]     ra_val;
	logic [WORD_W-1:0]     rb_val;
	alu_op_e               alu_op;
	ex_sel_e               ex_sel;
	logic                  use_imm; // operand b from sext(imm)
	logic                  use_hi;  // operand b from imm << 16
	logic                  gpr_we;
	logic                  is_branch;
	logic                  is_jump;

	// ------------------------------------------------------------------------
	// field split
	// ------------------------------------------------------------------------
	assign op       = opcode_e'(fetch.instr[31:26]);
	assign dst      = fetch.instr[25:21];
	assign ra_addr  = fetch.instr[20:16];
	assign rb_addr  = fetch.instr[15:11];
	assign imm      = fetch.instr[IMM_W-1:0];
	assign imm_sext = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
	assign imm_hi   = {imm, {(WORD_W-IMM_W){1'b0}}};

	// newest result wins: ex, then wb, then the file
	function automatic logic [WORD_W-1:0] fwd_pick(
		input logic [REG_ADDR_W-1:0] addr,
		input logic [WORD_W-1:0]     rf_data,
		input fwd_t                  ex,
		input fwd_t                  wb
	);
		if (ex.we && ex.addr != '0 && ex.addr == addr)
			return ex.data;
		if (wb.we && wb.addr != '0 && wb.addr == addr)
			return wb.data;
		return rf_data; // r0 already zero from the file
	endfunction

	assign ra_val = fwd_pick(ra_addr, ra_data, ex_fwd, wb_fwd);
	assign rb_val = fwd_pick(rb_addr, rb_data, ex_fwd, wb_fwd);

	// ------------------------------------------------------------------------
	// control decode
	// ------------------------------------------------------------------------
	always_comb begin
		alu_op    = ALU_NOP; // defaults give a bubble
		ex_sel    = EX_SEL_ALU;
		use_imm   = 1'b0;
		use_hi    = 1'b0;
		gpr_we    = 1'b0;
		is_branch = 1'b0;
		is_jump   = 1'b0;
		case (op)
			OP_ADD: begin
				alu_op = ALU_ADD;
				gpr_we = 1'b1;
			end
			OP_SUB: begin
				alu_op = ALU_SUB;
				gpr_we = 1'b1;
			end
			OP_AND: begin
				alu_op = ALU_AND;
				gpr_we = 1'b1;
			end
			OP_OR: begin
				alu_op = ALU_OR;
				gpr_we = 1'b1;
			end
			OP_XOR: begin
				alu_op = ALU_XOR;
				gpr_we = 1'b1;
			end
			OP_SLT: begin
				alu_op = ALU_SLT;
				gpr_we = 1'b1;
			end
			OP_ADDI: begin
				alu_op  = ALU_ADD;
				use_imm = 1'b1;
				gpr_we  = 1'b1;
			end
			OP_LUI: begin
				alu_op = ALU_PASS_B; // b already shifted
				use_hi = 1'b1;
				gpr_we = 1'b1;
			end
			OP_BEQ: is_branch = 1'b1; // compare done in ex
			OP_JAL: begin
				is_jump = 1'b1;
				ex_sel  = EX_SEL_LINK;
				gpr_we  = 1'b1;
			end
			default: ; // nop and unknown codes
		endcase
	end

	// ------------------------------------------------------------------------
	// ID/EX payload
	// ------------------------------------------------------------------------
	always_comb begin
		dec.en        = fetch.valid;
		dec.alu_op    = alu_op;
		dec.alu_in_0  = ra_val;
		dec.alu_in_1  = use_hi ? imm_hi : (use_imm ? imm_sext : rb_val);
		dec.ra_val    = ra_val;
		dec.rb_val    = rb_val;
		dec.is_branch = is_branch;
		dec.is_jump   = is_jump;
		dec.target    = fetch.pc + imm_sext; // pc relative, word addressed
		dec.dst_addr  = dst;
		dec.gpr_we    = gpr_we;
		dec.ex_sel    = ex_sel;
		dec.link_val  = fetch.pc + WORD_W'(1);
	end

endmodule

// File: logic/id_reg.sv
`timescale 1ns/1ps

module id_reg
	import cpu_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   hold,  // external back-pressure
	input  logic   flush, // taken branch or jump in ex
	input  id_ex_t dec,
	output id_ex_t id
);

	// ------------------------------------------------------------------------
	// ID/EX register
	// priority: hold > flush > load
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id <= ID_EX_BUBBLE; // start empty
		end else if (hold) begin
			id <= id; // frozen, instr stays for ex
		end else if (flush) begin
			// kill the instr fetched behind the redirect
			id <= ID_EX_BUBBLE;
		end else begin
			id <= dec;
		end
	end

endmodule

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb
	import cpu_pkg::*;
();

	localparam int PROG_LEN     = 64;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_CYCLES   = PROG_LEN * 10 + 50; // worst case per instr, plus drain
	localparam int HOLD_PCT     = 20;
	localparam opcode_e OP_LIST [11] = '{OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SLT, OP_ADDI, OP_LUI, OP_BEQ, OP_JAL};

	logic      clk = 1'b0;
	logic      rst_n;
	logic      hold;
	fetch_t    fetch;
	redirect_t redirect;
	commit_t   commit;

	logic [WORD_W-1:0] prog [PROG_LEN];
	commit_t           exp_commits [$];   // from the ISA model, program order
	redirect_t         exp_redirects [$];

	core_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.fetch    (fetch),
		.redirect (redirect),
		.commit   (commit)
	);

	always #20 clk = ~clk; // 40 ns period

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_commit(input string name, input commit_t exp, input commit_t act);
		if (act !== exp)
			abort_run($sformatf("ERR %s: expected dst=%0d data=%h, actual dst=%0d data=%h",
				name, exp.dst, exp.data, act.dst, act.data));
	endtask

	task automatic check_redirect(input string name, input redirect_t exp,
		input redirect_t act);
		if (act !== exp)
			abort_run($sformatf("ERR %s: expected target=%h, actual target=%h",
				name, exp.target, act.target));
	endtask

	// regs kept to r0..r7 so neighbours often depend on each other
	function automatic logic [WORD_W-1:0] rand_instr();
		opcode_e               opc;
		logic [REG_ADDR_W-1:0] dst;
		logic [REG_ADDR_W-1:0] ra;
		logic [IMM_W-1:0]      imm;
		int unsigned           pick;
		pick = $urandom_range(0, 15);
		dst  = REG_ADDR_W'($urandom_range(0, 7));
		ra   = REG_ADDR_W'($urandom_range(0, 7));
		imm  = IMM_W'($urandom); // full range for addi and lui
		if (pick == 11)
			return {6'h3f, dst, ra, imm}; // unknown code, acts as nop
		opc = (pick > 11) ? OP_ADDI : OP_LIST[pick]; // extra addi to seed values
		if (opc == OP_BEQ || opc == OP_JAL)
			imm = IMM_W'($urandom_range(1, 8)); // forward only, program ends
		else if (opc != OP_ADDI && opc != OP_LUI)
			imm[15:11] = REG_ADDR_W'($urandom_range(0, 7)); // rb
		return {opc, dst, ra, imm};
	endfunction

	// ------------------------------------------------------------------------
	// ISA model, one instr at a time
	// ------------------------------------------------------------------------
	task automatic run_model();
		logic [WORD_W-1:0]     regs [NUM_GPR];
		logic [WORD_W-1:0]     instr;
		logic [WORD_W-1:0]     a;
		logic [WORD_W-1:0]     b;
		logic [WORD_W-1:0]     sext;
		logic [WORD_W-1:0]     res;
		logic [REG_ADDR_W-1:0] dst;
		logic [OPC_W-1:0]      opc;
		logic                  wr;
		int                    pc;
		for (int i = 0; i < NUM_GPR; i++)
			regs[i] = '0;
		pc = 0;
		while (pc < PROG_LEN) begin
			instr = prog[pc];
			opc   = instr[31:26];
			dst   = instr[25:21];
			a     = regs[instr[20:16]]; // r0 never written, reads zero
			b     = regs[instr[15:11]];
			sext  = {{16{instr[15]}}, instr[15:0]};
			wr    = 1'b1;
			res   = '0;
			case (opc)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				OP_ADDI: res = a + sext;
				OP_LUI:  res = {instr[15:0], 16'h0000};
				OP_JAL:  res = WORD_W'(pc + 1); // link
				default: wr = 1'b0;             // beq, nop, unknown
			endcase
			if (wr) begin
				exp_commits.push_back('{valid: 1'b1, dst: dst, data: res});
				if (dst != '0)
					regs[dst] = res;
			end
			if (opc == OP_JAL || (opc == OP_BEQ && a == b)) begin
				exp_redirects.push_back('{valid: 1'b1, target: WORD_W'(pc) + sext});
				pc = pc + int'(sext);
			end else begin
				pc++;
			end
		end
	endtask

	// fetch port plus a fresh random hold
	task automatic drive_fetch(input int pc);
		hold        = ($urandom_range(0, 99) < HOLD_PCT);
		fetch.valid = (pc < PROG_LEN);
		fetch.pc    = WORD_W'(pc);
		if (pc < PROG_LEN)
			fetch.instr = prog[pc];
		else
			fetch.instr = '0; // past the end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int unsigned seed_ret;
		int          pc;
		int          cycles;
		int          n_commit;
		int          n_redirect;
		logic        accepted;
		commit_t     cm;
		redirect_t   rd;
		seed_ret = $urandom(32'hb6da);
		rst_n    = 1'b0;
		hold     = 1'b0;
		fetch    = '0;
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = rand_instr();
		run_model();
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			if (commit.valid !== 1'b0 || redirect.valid !== 1'b0)
				abort_run("commit or redirect was valid during reset");
		end
		@(posedge clk);
		#1;
		rst_n      = 1'b1;
		pc         = 0;
		cycles     = 0;
		n_commit   = 0;
		n_redirect = 0;
		drive_fetch(pc);
		while (pc < PROG_LEN || exp_commits.size() != 0 || exp_redirects.size() != 0) begin
			@(negedge clk); // inputs and outputs settled for the coming edge
			cycles++;
			if (cycles > MAX_CYCLES)
				abort_run("program did not finish before the cycle limit");
			accepted = fetch.valid && !hold && !redirect.valid;
			cm       = commit;
			rd       = redirect;
			if (cm.valid !== 1'b0) begin
				if (exp_commits.size() == 0)
					abort_run("a commit came out with no instruction left to retire");
				else
					check_commit($sformatf("commit %0d", n_commit), exp_commits.pop_front(), cm);
				n_commit++;
			end
			if (rd.valid !== 1'b0) begin
				if (exp_redirects.size() == 0)
					abort_run("a redirect came out that the program does not take");
				else
					check_redirect($sformatf("redirect %0d", n_redirect),
						exp_redirects.pop_front(), rd);
				n_redirect++;
			end
			@(posedge clk);
			#1;
			if (rd.valid)
				pc = int'(rd.target); // instr behind it is dropped
			else if (accepted)
				pc++;
			drive_fetch(pc);
		end
		hold = 1'b0;
		repeat (4) begin // idle tail, nothing more may retire
			@(negedge clk);
			if (commit.valid !== 1'b0 || redirect.valid !== 1'b0)
				abort_run("commit or redirect came out after the program ended");
		end
		$display("checked %0d commits and %0d redirects", n_commit, n_redirect);
		$display("Test passed");
		$finish;
	end

endmodule
